//--- ahb_axi_bridge.f
hdl/ahb_axi_pkg.sv
hdl/bridge_cmd_if.sv
hdl/access_check.sv
hdl/ahb_bus_ctrl.sv
hdl/cmd_buffer.sv
hdl/ahb_axi_bridge.sv
test/tb_ahb_axi_bridge.sv

//--- hdl/access_check.sv
`timescale 1ns/1ps

// Region and alignment rules for one captured AHB access
module access_check
   import ahb_axi_pkg::*;
(
   input  addr_t  addr,
   input  hsize_t size,
   input  logic   write,
   output logic   access_error
);

   logic in_dccm;
   logic in_iccm;
   logic size_ok;        // Word or doubleword
   logic region_err;
   logic size_err;
   logic align_err;

   // ****************************************
   // Region decode
   // ****************************************
   assign in_dccm = ((addr & ~(DCCM_SIZE - 32'd1)) == DCCM_BASE);
   assign in_iccm = ((addr & ~(ICCM_SIZE - 32'd1)) == ICCM_BASE);

   assign region_err = ~(in_dccm | in_iccm);   // Not for either CCM

   // ICCM takes only wide accesses, DCCM only for writes
   assign size_ok  = (size == SIZE_WORD) | (size == SIZE_DWORD);
   assign size_err = (in_iccm | (in_dccm & write)) & ~size_ok;

   // ****************************************
   // Alignment
   // ****************************************
   always_comb begin
      case (size)
         SIZE_HALF:  align_err = addr[0];
         SIZE_WORD:  align_err = |addr[1:0];
         SIZE_DWORD: align_err = |addr[2:0];
         default:    align_err = 1'b0;          // Byte is always aligned
      endcase
   end

   assign access_error = region_err | size_err | align_err;

endmodule

//--- hdl/ahb_axi_bridge.sv
`timescale 1ns/1ps

// AHB-Lite to AXI4 bridge, single beat transfers
module ahb_axi_bridge
   import ahb_axi_pkg::*;
(
   input  logic      bus_clk,
   input  logic      rst_n,

   // AHB-Lite slave
   input  addr_t     haddr,
   input  hsize_t    hsize,
   input  htrans_t   htrans,
   input  logic      hwrite,
   input  data_t     hwdata,
   input  logic      hsel,
   input  logic      hreadyin,
   output data_t     hrdata,
   output logic      hreadyout,
   output logic      hresp,

   // AXI4 write address and data
   output logic      awvalid,
   input  logic      awready,
   output addr_t     awaddr,
   output hsize_t    awsize,
   output logic      wvalid,
   input  logic      wready,          // Assumed high together with awready
   output data_t     wdata,
   output strb_t     wstrb,

   // AXI4 read address and data
   output logic      arvalid,
   input  logic      arready,
   output addr_t     araddr,
   output hsize_t    arsize,
   input  logic      rvalid,
   input  data_t     rdata,
   input  axi_resp_t rresp
);

   bridge_cmd_if u_cmd_if ();

   // ****************************************
   // AHB side
   // ****************************************
   ahb_bus_ctrl u_ahb_bus_ctrl (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .haddr     (haddr),
      .hsize     (hsize),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hsel      (hsel),
      .hreadyin  (hreadyin),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .rresp     (rresp),
      .hrdata    (hrdata),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .cmd       (u_cmd_if.ctrl)
   );

   // ****************************************
   // AXI side
   // ****************************************
   cmd_buffer u_cmd_buffer (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .hwdata  (hwdata),
      .awready (awready),
      .arready (arready),
      .cmd     (u_cmd_if.buffer),
      .awvalid (awvalid),
      .awaddr  (awaddr),
      .awsize  (awsize),
      .wvalid  (wvalid),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .arvalid (arvalid),
      .araddr  (araddr),
      .arsize  (arsize)
   );

endmodule

//--- hdl/ahb_axi_pkg.sv
package ahb_axi_pkg;

   // ****************************************
   // Bus widths
   // ****************************************
   localparam int ADDR_W = 32;                 // AHB and AXI address
   localparam int DATA_W = 64;                 // Data bus, both sides
   localparam int STRB_W = DATA_W / 8;         // One strobe per byte lane

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [1:0]        axi_resp_t;      // OKAY when zero, error otherwise

   // ****************************************
   // Memory regions
   // ****************************************
   // Both regions are size aligned, so a masked compare is enough
   localparam addr_t DCCM_BASE = 32'hF004_0000;
   localparam addr_t DCCM_SIZE = 32'h0001_0000; // 64 KiB
   localparam addr_t ICCM_BASE = 32'hEE00_0000;
   localparam addr_t ICCM_SIZE = 32'h0001_0000; // 64 KiB

   // ****************************************
   // Encodings
   // ****************************************
   typedef enum logic [2:0] {
      SIZE_BYTE  = 3'b000,
      SIZE_HALF  = 3'b001,
      SIZE_WORD  = 3'b010,
      SIZE_DWORD = 3'b011
   } hsize_t;                                  // Same code on AHB hsize and AXI axsize

   typedef enum logic [1:0] {
      TRANS_IDLE   = 2'b00,
      TRANS_BUSY   = 2'b01,
      TRANS_NONSEQ = 2'b10,
      TRANS_SEQ    = 2'b11
   } htrans_t;                                 // Bit 1 set means a real transfer

   typedef enum logic [1:0] {
      ST_IDLE = 2'b00,                         // No command in flight
      ST_WR   = 2'b01,                         // Write address phase taken
      ST_RD   = 2'b10,                         // Read address phase taken
      ST_PEND = 2'b11                          // Read issued, waiting on R
   } bus_state_t;

endpackage

//--- hdl/ahb_bus_ctrl.sv
`timescale 1ns/1ps

// AHB-Lite slave side of the bridge
module ahb_bus_ctrl
   import ahb_axi_pkg::*;
(
   input  logic       bus_clk,
   input  logic       rst_n,

   // AHB address and data phase
   input  addr_t      haddr,
   input  hsize_t     hsize,
   input  htrans_t    htrans,
   input  logic       hwrite,
   input  logic       hsel,
   input  logic       hreadyin,

   // AXI read return
   input  logic       rvalid,
   input  data_t      rdata,
   input  axi_resp_t  rresp,

   output data_t      hrdata,
   output logic       hreadyout,
   output logic       hresp,

   bridge_cmd_if.ctrl cmd
);

   bus_state_t state_q, state_d;
   logic       state_en;

   logic       hready;          // Transfer completes this cycle
   logic       hready_q;
   logic       hresp_q;
   htrans_t    htrans_in;       // htrans qualified by hsel
   htrans_t    htrans_q;
   logic       addr_en;

   // Captured address phase
   hsize_t     hsize_q;
   logic       hwrite_q;
   addr_t      haddr_q;

   logic       access_error;
   logic       load_d;

   // Read return buffer
   logic       rdata_en;
   data_t      rdata_q;
   logic       read_error_d;
   logic       read_error_q;    // High for one cycle only

   // ****************************************
   // Bus FSM
   // ****************************************
   always_comb begin
      state_d      = ST_IDLE;
      state_en     = 1'b0;
      load_d       = 1'b0;
      rdata_en     = 1'b0;
      read_error_d = 1'b0;
      case (state_q)
         ST_IDLE: begin
            state_d  = hwrite ? ST_WR : ST_RD;
            state_en = hready & htrans[1] & hsel;   // Only on NONSEQ or SEQ
         end
         ST_WR: begin
            // Next transfer may follow right behind the write data
            if (hresp | (htrans == TRANS_IDLE) | ~hsel)
               state_d = ST_IDLE;
            else
               state_d = hwrite ? ST_WR : ST_RD;
            state_en = ~cmd.full | hresp;
            // No load on error, or when the master inserts BUSY
            load_d   = ~cmd.full & ~(hresp | ((htrans == TRANS_BUSY) & hsel));
         end
         ST_RD: begin
            state_d  = hresp ? ST_IDLE : ST_PEND;   // Error ends the read here
            state_en = ~cmd.full | hresp;
            load_d   = ~cmd.full & ~hresp;
         end
         ST_PEND: begin
            state_d      = ST_IDLE;
            state_en     = rvalid & ~cmd.pend_write;  // Data is back
            rdata_en     = state_en;
            read_error_d = state_en & (|rresp);
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ST_IDLE;
      end else if (state_en) begin
         state_q <= state_d;
      end
   end

   // ****************************************
   // AHB handshake and response
   // ****************************************
   assign hready    = hreadyout & hreadyin;
   assign htrans_in = hsel ? htrans : TRANS_IDLE;
   assign addr_en   = hready & htrans[1];

   // Check applies only while a captured transfer is being served
   assign hresp = ((htrans_q != TRANS_IDLE) & (state_q != ST_IDLE) & access_error) |
                  read_error_q |                 // AXI read error
                  (hresp_q & ~hready_q);         // Second cycle of the error

   // Low on the first error cycle, high on the second
   assign hreadyout = hresp ? (hresp_q & ~hready_q) :
                      ((~cmd.full | (state_q == ST_IDLE)) &
                       ~((state_q == ST_RD) | (state_q == ST_PEND)) &
                       ~read_error_q);

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         hresp_q      <= 1'b0;
         hready_q     <= 1'b0;
         htrans_q     <= TRANS_IDLE;
         read_error_q <= 1'b0;
      end else begin
         hresp_q      <= hresp;
         hready_q     <= hready;
         htrans_q     <= htrans_in;
         read_error_q <= read_error_d;
      end
   end

   // Address phase capture
   always_ff @(posedge bus_clk) begin
      if (addr_en) begin
         hsize_q  <= hsize;
         hwrite_q <= hwrite;
         haddr_q  <= haddr;
      end
   end

   // Read data held until the master takes it
   always_ff @(posedge bus_clk) begin
      if (rdata_en) begin
         rdata_q <= rdata;
      end
   end

   assign hrdata = rdata_q;

   access_check u_access_check (
      .addr         (haddr_q),
      .size         (hsize_q),
      .write        (hwrite_q),
      .access_error (access_error)
   );

   // ****************************************
   // Command to the buffer
   // ****************************************
   assign cmd.load  = load_d;
   assign cmd.abort = hresp;
   assign cmd.write = hwrite_q;
   assign cmd.size  = hsize_q;
   assign cmd.addr  = haddr_q;

endmodule

//--- hdl/bridge_cmd_if.sv
`timescale 1ns/1ps

// Command load and status between bus controller and command buffer
interface bridge_cmd_if
   import ahb_axi_pkg::*;
();

   logic   load;        // One cycle pulse, capture the command
   logic   abort;       // Live hresp from the controller
   logic   write;       // Registered hwrite
   hsize_t size;        // Registered hsize
   addr_t  addr;        // Registered haddr
   logic   full;        // Entry held and not leaving this cycle
   logic   pend_write;  // Held command is a write

   modport ctrl (
      output load, abort, write, size, addr,
      input  full, pend_write
   );

   modport buffer (
      input  load, abort, write, size, addr,
      output full, pend_write
   );

endinterface

//--- hdl/cmd_buffer.sv
`timescale 1ns/1ps

// One entry command buffer feeding the AXI command channels
module cmd_buffer
   import ahb_axi_pkg::*;
(
   input  logic         bus_clk,
   input  logic         rst_n,

   input  data_t        hwdata,       // Data phase of the write
   input  logic         awready,
   input  logic         arready,

   bridge_cmd_if.buffer cmd,

   output logic         awvalid,
   output addr_t        awaddr,
   output hsize_t       awsize,
   output logic         wvalid,
   output data_t        wdata,
   output strb_t        wstrb,
   output logic         arvalid,
   output addr_t        araddr,
   output hsize_t       arsize
);

   logic   vld_q;                     // Entry valid
   logic   write_q;                   // Entry is a write
   hsize_t size_q;
   addr_t  addr_q;
   data_t  wdata_q;
   strb_t  strb_q;
   strb_t  strb_d;
   logic   accept;                    // AXI takes the command
   logic   clear;

   // ****************************************
   // Byte strobes
   // ****************************************
   always_comb begin
      case (cmd.size)
         SIZE_BYTE:  strb_d = 8'b0000_0001 << cmd.addr[2:0];
         SIZE_HALF:  strb_d = 8'b0000_0011 << cmd.addr[2:0];
         SIZE_WORD:  strb_d = 8'b0000_1111 << cmd.addr[2:0];
         SIZE_DWORD: strb_d = '1;           // All lanes
         default:    strb_d = '0;
      endcase
   end

   assign accept   = (awvalid & awready) | (arvalid & arready);
   assign clear    = (accept & ~cmd.load) | (cmd.abort & ~write_q);  // Error drops a read
   assign cmd.full = vld_q & ~accept;
   assign cmd.pend_write = write_q;

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q   <= 1'b0;
         write_q <= 1'b0;
      end else begin
         if (clear)
            vld_q <= 1'b0;
         else if (cmd.load)
            vld_q <= 1'b1;
         if (cmd.load)
            write_q <= cmd.write;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (cmd.load) begin
         size_q  <= cmd.size;
         addr_q  <= cmd.addr;
         wdata_q <= hwdata;             // AHB data phase lines up with load
         strb_q  <= strb_d;
      end
   end

   // ****************************************
   // AXI command channels
   // ****************************************
   assign awvalid = vld_q & write_q;
   assign awaddr  = addr_q;
   assign awsize  = size_q;
   assign wvalid  = vld_q & write_q;    // Data goes with the address
   assign wdata   = wdata_q;
   assign wstrb   = strb_q;
   assign arvalid = vld_q & ~write_q;
   assign araddr  = addr_q;
   assign arsize  = size_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   --top-module tb_ahb_axi_bridge \
   -f ahb_axi_bridge.f \
   -o sim_tb

./obj_dir/sim_tb

//--- test/tb_ahb_axi_bridge.sv
`timescale 1ns/1ps

module tb_ahb_axi_bridge
   import ahb_axi_pkg::*;
();

   localparam int NROWS   = 18;
   localparam int TIMEOUT = 200;          // Cycles per wait loop

   typedef struct packed {
      logic      wr;
      addr_t     addr;
      hsize_t    size;
      data_t     wdata;
      data_t     rdata;                    // Returned on R
      axi_resp_t rresp;
      logic      err;                      // AHB error response expected
   } row_t;

   logic      bus_clk;
   logic      rst_n;
   addr_t     haddr;
   hsize_t    hsize;
   htrans_t   htrans;
   logic      hwrite;
   data_t     hwdata;
   logic      hsel;
   logic      hreadyin;
   data_t     hrdata;
   logic      hreadyout;
   logic      hresp;
   logic      awvalid;
   logic      awready;
   logic      wvalid;
   logic      wready;
   addr_t     awaddr;
   addr_t     araddr;
   hsize_t    awsize;
   hsize_t    arsize;
   data_t     wdata;
   data_t     rdata;
   strb_t     wstrb;
   logic      arvalid;
   logic      arready;
   logic      rvalid;
   axi_resp_t rresp;

   row_t      rows [NROWS];
   logic [31:0] lfsr_q;
   // Expected AXI write commands in issue order
   addr_t     exp_aw_addr [$];
   hsize_t    exp_aw_size [$];
   data_t     exp_aw_data [$];
   logic      rd_expected;
   addr_t     exp_ar_addr;
   hsize_t    exp_ar_size;
   data_t     cur_rdata;
   axi_resp_t cur_rresp;

   ahb_axi_bridge u_ahb_axi_bridge (.*);

   // ****************************************
   // Clock, reset, random source
   // ****************************************
   initial begin
      bus_clk = 1'b0;
      forever #20 bus_clk = ~bus_clk;      // 40 ns period
   end

   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b)
         lfsr_q = lfsr_q ^ 32'h8020_0003;  // Galois taps
      return b;
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++)
         v = (v << 1) | int'(lfsr_bit());   // One step per bit
      return v;
   endfunction

   // Lanes from the low address bits up through the transfer size
   function automatic strb_t exp_strb(input addr_t a, input hsize_t s);
      strb_t m;
      int    lo;
      int    nbytes;
      lo     = int'(a[2:0]);
      nbytes = 1 << int'(s);
      for (int i = 0; i < STRB_W; i++)
         m[i] = (i >= lo) && (i < lo + nbytes);
      return m;
   endfunction

   // ****************************************
   // Compare tasks
   // ****************************************
   task automatic fail(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_addr(input addr_t act, input addr_t exp, input string what);
      if (act !== exp)
         fail($sformatf("Error at %0t: %s is %h, expected %h", $time, what, act, exp));
   endtask

   task automatic check_size(input hsize_t act, input hsize_t exp, input string what);
      if (act !== exp)
         fail($sformatf("Error at %0t: %s is %s, expected %s", $time, what,
                        act.name(), exp.name()));
   endtask

   task automatic check_strb(input strb_t act, input strb_t exp, input string what);
      if (act !== exp)
         fail($sformatf("Error at %0t: %s is %b, expected %b", $time, what, act, exp));
   endtask

   task automatic check_data(input data_t act, input data_t exp, input string what);
      if (act !== exp)
         fail($sformatf("Error at %0t: %s is %h, expected %h", $time, what, act, exp));
   endtask

   task automatic check_flag(input logic act, input logic exp, input string what);
      if (act !== exp)
         fail($sformatf("Error at %0t: %s is %b, expected %b", $time, what, act, exp));
   endtask

   // ****************************************
   // AXI responder
   // ****************************************
   initial begin
      int     n;
      addr_t  e_addr;
      hsize_t e_size;
      data_t  e_data;
      awready = 1'b0;
      wready  = 1'b0;
      arready = 1'b0;
      rvalid  = 1'b0;
      rdata   = '0;
      rresp   = '0;
      @(posedge rst_n);
      forever begin
         @(posedge bus_clk);
         #2;
         awready = 1'b0;
         wready  = 1'b0;
         arready = 1'b0;
         rvalid  = 1'b0;
         if (awvalid) begin
            n = rand_bits(2);               // 0 to 3 cycles of stall
            if (n > 0) begin
               repeat (n) @(posedge bus_clk);
               #2;
            end
            if (exp_aw_addr.size() == 0)
               fail("Unexpected write command on AXI");
            e_addr = exp_aw_addr.pop_front();
            e_size = exp_aw_size.pop_front();
            e_data = exp_aw_data.pop_front();
            check_flag(wvalid, 1'b1, "wvalid");
            check_addr(awaddr, e_addr, "awaddr");
            check_size(awsize, e_size, "awsize");
            check_strb(wstrb, exp_strb(e_addr, e_size), "wstrb");
            check_data(wdata, e_data, "wdata");
            awready = 1'b1;                 // Both together
            wready  = 1'b1;
         end else if (arvalid) begin
            n = rand_bits(2);
            if (n > 0) begin
               repeat (n) @(posedge bus_clk);
               #2;
            end
            if (!rd_expected)
               fail("Unexpected read command on AXI");
            check_addr(araddr, exp_ar_addr, "araddr");
            check_size(arsize, exp_ar_size, "arsize");
            rd_expected = 1'b0;
            arready = 1'b1;
            @(posedge bus_clk);
            #2;
            arready = 1'b0;
            rvalid  = 1'b1;                 // Data one cycle after the handshake
            rdata   = cur_rdata;
            rresp   = cur_rresp;
         end
      end
   end

   // ****************************************
   // AHB driver
   // ****************************************
   task automatic next_cycle();
      @(posedge bus_clk);
      #2;
   endtask

   // Let the buffer empty before a read or an error row
   task automatic wait_axi_idle();
      int t;
      t = 0;
      while (awvalid || arvalid || exp_aw_addr.size() != 0) begin
         next_cycle();
         t++;
         if (t > TIMEOUT)
            fail("AXI command never drained");
      end
   endtask

   task automatic do_transfer(input row_t r);
      int   t;
      logic prev_hresp;
      logic prev_ready;
      logic axi_cmd;
      // A legal read still goes out on AXI when its R response is an error
      axi_cmd = !r.err || (!r.wr && (r.rresp != 2'd0));
      if (!r.wr || r.err)
         wait_axi_idle();
      if (r.wr && axi_cmd) begin
         exp_aw_addr.push_back(r.addr);
         exp_aw_size.push_back(r.size);
         exp_aw_data.push_back(r.wdata);
      end
      rd_expected = !r.wr && axi_cmd;
      exp_ar_addr = r.addr;
      exp_ar_size = r.size;
      cur_rdata   = r.rdata;
      cur_rresp   = r.rresp;
      // Address phase
      haddr  = r.addr;
      hsize  = r.size;
      hwrite = r.wr;
      htrans = TRANS_NONSEQ;
      hsel   = 1'b1;
      t = 0;
      @(negedge bus_clk);
      while (!hreadyout) begin
         next_cycle();
         @(negedge bus_clk);
         t++;
         if (t > TIMEOUT)
            fail("hreadyout never high for the address phase");
      end
      next_cycle();
      // Data phase
      htrans = TRANS_IDLE;
      if (r.wr)
         hwdata = r.wdata;
      t = 0;
      prev_hresp = 1'b0;
      prev_ready = 1'b1;
      @(negedge bus_clk);
      while (!hreadyout) begin
         if (!r.err)
            check_flag(hresp, 1'b0, "hresp during stall");
         else if (!axi_cmd)
            check_flag(awvalid | arvalid, 1'b0, "AXI valid on error row");
         prev_hresp = hresp;
         prev_ready = hreadyout;
         next_cycle();
         @(negedge bus_clk);
         t++;
         if (t > TIMEOUT)
            fail("hreadyout never returned");
      end
      check_flag(hresp, r.err, "hresp");
      if (r.err) begin
         check_flag(prev_hresp, 1'b1, "hresp in first error cycle");
         check_flag(prev_ready, 1'b0, "hreadyout in first error cycle");
         next_cycle();
         @(negedge bus_clk);
         check_flag(hresp, 1'b0, "hresp after error");
         check_flag(awvalid | arvalid, 1'b0, "AXI valid after error");
      end else if (!r.wr) begin
         check_data(hrdata, r.rdata, "hrdata");
      end
      next_cycle();
   endtask

   // ****************************************
   // Table and main sequence
   // ****************************************
   function automatic row_t mk(input logic wr, input addr_t a, input hsize_t s,
                               input data_t d, input axi_resp_t rr, input logic e);
      row_t r;
      r.wr    = wr;
      r.addr  = a;
      r.size  = s;
      r.wdata = d;
      r.rdata = ~d;
      r.rresp = rr;
      r.err   = e;
      return r;
   endfunction

   initial begin
      lfsr_q      = 32'h2dc1;
      rst_n       = 1'b0;
      haddr       = '0;
      hsize       = SIZE_BYTE;
      htrans      = TRANS_IDLE;
      hwrite      = 1'b0;
      hwdata      = '0;
      hsel        = 1'b0;
      hreadyin    = 1'b1;
      rd_expected = 1'b0;
      exp_ar_addr = '0;
      exp_ar_size = SIZE_BYTE;
      cur_rdata   = '0;
      cur_rresp   = '0;
      rows[0]  = mk(1, 32'hF004_0008, SIZE_DWORD, 64'h0123_4567_89AB_CDEF, 2'd0, 0);
      rows[1]  = mk(1, 32'hF004_0014, SIZE_WORD,  64'hDEAD_BEEF_0000_0000, 2'd0, 0);
      rows[2]  = mk(1, 32'hF004_0020, SIZE_WORD,  64'h0000_0000_CAFE_F00D, 2'd0, 0);
      rows[3]  = mk(1, 32'hF004_0001, SIZE_BYTE,  64'h0000_0000_0000_5A00, 2'd0, 1);
      rows[4]  = mk(0, 32'hF004_0102, SIZE_HALF,  64'h1111_2222_3333_4444, 2'd0, 0);
      rows[5]  = mk(0, 32'hF004_0106, SIZE_HALF,  64'h5555_6666_7777_8888, 2'd0, 0);
      rows[6]  = mk(0, 32'hF004_0200, SIZE_DWORD, 64'h9999_AAAA_BBBB_CCCC, 2'd0, 0);
      rows[7]  = mk(0, 32'hF004_0002, SIZE_WORD,  64'h0,                   2'd0, 1);
      rows[8]  = mk(1, 32'hF004_0011, SIZE_HALF,  64'h0,                   2'd0, 1);
      rows[9]  = mk(0, 32'h1000_0000, SIZE_WORD,  64'h0,                   2'd0, 1);
      rows[10] = mk(0, 32'hEE00_0003, SIZE_BYTE,  64'h0,                   2'd0, 1);
      rows[11] = mk(1, 32'hEE00_0004, SIZE_BYTE,  64'h0,                   2'd0, 1);
      rows[12] = mk(0, 32'hF004_0300, SIZE_DWORD, 64'h0F0F_0F0F_0F0F_0F0F, 2'd2, 1);
      rows[13] = mk(1, 32'hEE00_0010, SIZE_DWORD, 64'h2468_ACE0_1357_9BDF, 2'd0, 0);
      // Back to back writes under random awready stalls
      rows[14] = mk(1, 32'hF004_1000, SIZE_DWORD, 64'hA5A5_0000_0000_0001, 2'd0, 0);
      rows[15] = mk(1, 32'hF004_1008, SIZE_WORD,  64'h0000_0002_A5A5_A5A5, 2'd0, 0);
      rows[16] = mk(1, 32'hF004_100C, SIZE_WORD,  64'h0000_0003_5A5A_5A5A, 2'd0, 0);
      rows[17] = mk(1, 32'hF004_1010, SIZE_DWORD, 64'hFFFF_0000_FFFF_0004, 2'd0, 0);
      repeat (5) @(posedge bus_clk);
      #2;
      rst_n = 1'b1;
      @(negedge bus_clk);
      check_flag(hreadyout, 1'b1, "hreadyout after reset");
      check_flag(hresp, 1'b0, "hresp after reset");
      check_flag(awvalid | wvalid | arvalid, 1'b0, "AXI valid after reset");
      next_cycle();
      for (int i = 0; i < NROWS; i++)
         do_transfer(rows[i]);
      wait_axi_idle();
      if (exp_aw_addr.size() != 0 || rd_expected) begin
         $display("Expected AXI commands never arrived");
         $display("Errors found");
         $fatal(1);
      end else begin
         $display("No errors");
         $finish;
      end
   end

endmodule
